// ==== vga_defines.svh ====
// XGA 1024x768 timing, 1344x806 total, at an external pixel clock
// sync pulses are active high here, unlike the standard negative polarity
// values are plain macros and carry no width of their own

`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// horizontal timing in pixels
`define H_ACTIVE 1024
`define H_FRONT 24
`define H_SYNC 136
`define H_TOTAL 1344

// vertical timing in lines
`define V_ACTIVE 768
`define V_FRONT 3
`define V_SYNC 6
`define V_TOTAL 806

// width of hcount and vcount, enough for H_TOTAL
`define CNT_W 11

// overlay rectangle size in pixels
`define RECT_W 48
`define RECT_H 64

// cycles from the counter register to the output ports
`define PIPE_DEPTH 3

`endif

// ==== vga_timing_pkg.sv ====
// timing bundle that travels from stage to stage
// field order fixes the packed layout, 26 bits in all

`include "vga_defines.svh"

package vga_timing_pkg;

        // hcount and vcount sit in the upper bits
        typedef struct packed {
                logic [`CNT_W-1:0] hcount;
                logic [`CNT_W-1:0] vcount;
                logic              hsync;
                logic              hblnk;
                logic              vsync;
                logic              vblnk;
        } timing_t;

endpackage

// ==== vga_color_pkg.sv ====
// 4:4:4 colour and the registered output bundle
// rgb_t is red in [11:8], green in [7:4], blue in [3:0]

package vga_color_pkg;

        typedef logic [11:0] rgb_t;

        typedef struct packed {
                logic hs;
                logic vs;
                rgb_t rgb;
        } vga_out_t;

        localparam rgb_t COLOR_BLACK = 12'h000;
        localparam rgb_t COLOR_FRAME = 12'hfff;
        localparam rgb_t COLOR_BG    = 12'h48c;
        localparam rgb_t COLOR_RECT  = 12'hf80;

endpackage

// ==== pixel_delay.sv ====
// shift register for any packed payload, DEPTH must be at least 1
// every stage clears to all zeros on reset

`timescale 1ns/1ps

module pixel_delay #(
        parameter type payload_t = logic,
        parameter int  DEPTH     = 1
) (
        input  logic     pclk,
        input  logic     rst_n,
        input  payload_t d,
        output payload_t q
);

        payload_t stage [DEPTH];

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                stage[i] <= '0;
                        end
                end else begin
                        stage[0] <= d;
                        for (int i = 1; i < DEPTH; i++) begin
                                stage[i] <= stage[i-1];
                        end
                end
        end

        assign q = stage[DEPTH-1];

endmodule

// ==== vga_timing.sv ====
// free-running XGA counters with sync and blanking
// sync is active high; counting restarts at (0, 0) after reset

`timescale 1ns/1ps

`include "vga_defines.svh"

module vga_timing (
        input  logic              pclk,
        input  logic              rst_n,
        output logic [`CNT_W-1:0] hcount,
        output logic [`CNT_W-1:0] vcount,
        output logic              hsync,
        output logic              hblnk,
        output logic              vsync,
        output logic              vblnk
);

        localparam logic [`CNT_W-1:0] H_LAST = `CNT_W'(`H_TOTAL - 1);
        localparam logic [`CNT_W-1:0] V_LAST = `CNT_W'(`V_TOTAL - 1);
        localparam logic [`CNT_W-1:0] H_BLNK = `CNT_W'(`H_ACTIVE);
        localparam logic [`CNT_W-1:0] V_BLNK = `CNT_W'(`V_ACTIVE);
        localparam logic [`CNT_W-1:0] HS_BEG = `CNT_W'(`H_ACTIVE + `H_FRONT);
        localparam logic [`CNT_W-1:0] HS_END = `CNT_W'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1);
        localparam logic [`CNT_W-1:0] VS_BEG = `CNT_W'(`V_ACTIVE + `V_FRONT);
        localparam logic [`CNT_W-1:0] VS_END = `CNT_W'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1);

        logic [`CNT_W-1:0] hcount_nxt;
        logic [`CNT_W-1:0] vcount_nxt;

        // next position, vcount moves only when the line wraps
        always_comb begin
                hcount_nxt = (hcount == H_LAST) ? '0 : hcount + 1'b1;
                vcount_nxt = vcount;
                if (hcount == H_LAST) begin
                        vcount_nxt = (vcount == V_LAST) ? '0 : vcount + 1'b1;
                end
        end

        // flags are decoded from the next count so they land with it
        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        hcount <= '0;
                        vcount <= '0;
                        hsync  <= 1'b0;
                        hblnk  <= 1'b0;
                        vsync  <= 1'b0;
                        vblnk  <= 1'b0;
                end else begin
                        hcount <= hcount_nxt;
                        vcount <= vcount_nxt;
                        hsync  <= (hcount_nxt >= HS_BEG) && (hcount_nxt <= HS_END);
                        hblnk  <= (hcount_nxt >= H_BLNK);
                        vsync  <= (vcount_nxt >= VS_BEG) && (vcount_nxt <= VS_END);
                        vblnk  <= (vcount_nxt >= V_BLNK);
                end
        end

endmodule

// ==== draw_background.sv ====
// background stage, one cycle of latency for colour and timing
// black in blanking, a one-pixel white border, fixed colour inside

`timescale 1ns/1ps

`include "vga_defines.svh"

module draw_background
        import vga_timing_pkg::*, vga_color_pkg::*;
(
        input  logic              pclk,
        input  logic              rst_n,
        input  logic [`CNT_W-1:0] hcount_in,
        input  logic [`CNT_W-1:0] vcount_in,
        input  logic              hsync_in,
        input  logic              hblnk_in,
        input  logic              vsync_in,
        input  logic              vblnk_in,
        output logic [`CNT_W-1:0] hcount_out,
        output logic [`CNT_W-1:0] vcount_out,
        output logic              hsync_out,
        output logic              hblnk_out,
        output logic              vsync_out,
        output logic              vblnk_out,
        output rgb_t              rgb_out
);

        localparam logic [`CNT_W-1:0] H_EDGE = `CNT_W'(`H_ACTIVE - 1);
        localparam logic [`CNT_W-1:0] V_EDGE = `CNT_W'(`V_ACTIVE - 1);

        timing_t t_in;
        timing_t t_out;
        rgb_t    rgb_nxt;

        assign t_in = '{hcount: hcount_in, vcount: vcount_in, hsync: hsync_in,
                        hblnk: hblnk_in, vsync: vsync_in, vblnk: vblnk_in};

        pixel_delay #(.payload_t(timing_t), .DEPTH(1)) i_timing_dly (
                .pclk  (pclk),
                .rst_n (rst_n),
                .d     (t_in),
                .q     (t_out)
        );

        always_comb begin
                if (hblnk_in || vblnk_in) begin
                        rgb_nxt = COLOR_BLACK;
                end else if (hcount_in == '0 || hcount_in == H_EDGE ||
                             vcount_in == '0 || vcount_in == V_EDGE) begin
                        rgb_nxt = COLOR_FRAME;
                end else begin
                        rgb_nxt = COLOR_BG;
                end
        end

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        rgb_out <= COLOR_BLACK;
                end else begin
                        rgb_out <= rgb_nxt;
                end
        end

        assign hcount_out = t_out.hcount;
        assign vcount_out = t_out.vcount;
        assign hsync_out  = t_out.hsync;
        assign hblnk_out  = t_out.hblnk;
        assign vsync_out  = t_out.vsync;
        assign vblnk_out  = t_out.vblnk;

endmodule

// ==== draw_rect.sv ====
// solid rectangle overlay at (XPOS, YPOS), RECT_W by RECT_H pixels
// the rectangle must lie inside the active area, blanking is not rechecked

`timescale 1ns/1ps

`include "vga_defines.svh"

module draw_rect
        import vga_timing_pkg::*, vga_color_pkg::*;
#(
        parameter int XPOS = 128,
        parameter int YPOS = 99
) (
        input  logic              pclk,
        input  logic              rst_n,
        input  logic [`CNT_W-1:0] hcount_in,
        input  logic [`CNT_W-1:0] vcount_in,
        input  logic              hsync_in,
        input  logic              hblnk_in,
        input  logic              vsync_in,
        input  logic              vblnk_in,
        input  rgb_t              rgb_in,
        output logic [`CNT_W-1:0] hcount_out,
        output logic [`CNT_W-1:0] vcount_out,
        output logic              hsync_out,
        output logic              hblnk_out,
        output logic              vsync_out,
        output logic              vblnk_out,
        output rgb_t              rgb_out
);

        localparam logic [`CNT_W-1:0] X_BEG = `CNT_W'(XPOS);
        localparam logic [`CNT_W-1:0] X_END = `CNT_W'(XPOS + `RECT_W - 1);
        localparam logic [`CNT_W-1:0] Y_BEG = `CNT_W'(YPOS);
        localparam logic [`CNT_W-1:0] Y_END = `CNT_W'(YPOS + `RECT_H - 1);

        timing_t t_in;
        timing_t t_out;
        logic    in_rect;

        assign t_in = '{hcount: hcount_in, vcount: vcount_in, hsync: hsync_in,
                        hblnk: hblnk_in, vsync: vsync_in, vblnk: vblnk_in};

        pixel_delay #(.payload_t(timing_t), .DEPTH(1)) i_timing_dly (
                .pclk  (pclk),
                .rst_n (rst_n),
                .d     (t_in),
                .q     (t_out)
        );

        assign in_rect = (hcount_in >= X_BEG) && (hcount_in <= X_END) &&
                         (vcount_in >= Y_BEG) && (vcount_in <= Y_END);

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        rgb_out <= COLOR_BLACK;
                end else begin
                        rgb_out <= in_rect ? COLOR_RECT : rgb_in;
                end
        end

        assign hcount_out = t_out.hcount;
        assign vcount_out = t_out.vcount;
        assign hsync_out  = t_out.hsync;
        assign hblnk_out  = t_out.hblnk;
        assign vsync_out  = t_out.vsync;
        assign vblnk_out  = t_out.vblnk;

endmodule

// ==== vga_pipeline_top.sv ====
// XGA pixel pipeline, pclk and rst_n come straight from outside
// ports show counter position (h, v) three cycles after the counters hold it

`timescale 1ns/1ps

`include "vga_defines.svh"

module vga_pipeline_top
        import vga_timing_pkg::*, vga_color_pkg::*;
#(
        parameter int XPOS = 128,
        parameter int YPOS = 99
) (
        input  logic       pclk,
        input  logic       rst_n,
        output logic       hs,
        output logic       vs,
        output logic [3:0] r,
        output logic [3:0] g,
        output logic [3:0] b
);

        logic [`CNT_W-1:0] hcount, vcount, hcount_b, vcount_b;
        logic              hsync, hblnk, vsync, vblnk;
        logic              hsync_b, hblnk_b, vsync_b, vblnk_b;
        logic              hsync_c, vsync_c;
        rgb_t              rgb_b, rgb_c;
        vga_out_t          out_d, out_q;

        vga_timing i_timing (
                .pclk   (pclk),
                .rst_n  (rst_n),
                .hcount (hcount),
                .vcount (vcount),
                .hsync  (hsync),
                .hblnk  (hblnk),
                .vsync  (vsync),
                .vblnk  (vblnk)
        );

        draw_background i_background (
                .pclk       (pclk),
                .rst_n      (rst_n),
                .hcount_in  (hcount),
                .vcount_in  (vcount),
                .hsync_in   (hsync),
                .hblnk_in   (hblnk),
                .vsync_in   (vsync),
                .vblnk_in   (vblnk),
                .hcount_out (hcount_b),
                .vcount_out (vcount_b),
                .hsync_out  (hsync_b),
                .hblnk_out  (hblnk_b),
                .vsync_out  (vsync_b),
                .vblnk_out  (vblnk_b),
                .rgb_out    (rgb_b)
        );

        // only sync and colour go on past the rectangle
        draw_rect #(.XPOS(XPOS), .YPOS(YPOS)) i_rect (
                .pclk       (pclk),
                .rst_n      (rst_n),
                .hcount_in  (hcount_b),
                .vcount_in  (vcount_b),
                .hsync_in   (hsync_b),
                .hblnk_in   (hblnk_b),
                .vsync_in   (vsync_b),
                .vblnk_in   (vblnk_b),
                .rgb_in     (rgb_b),
                .hcount_out (),
                .vcount_out (),
                .hsync_out  (hsync_c),
                .hblnk_out  (),
                .vsync_out  (vsync_c),
                .vblnk_out  (),
                .rgb_out    (rgb_c)
        );

        assign out_d = '{hs: hsync_c, vs: vsync_c, rgb: rgb_c};

        pixel_delay #(.payload_t(vga_out_t), .DEPTH(1)) i_out_reg (
                .pclk  (pclk),
                .rst_n (rst_n),
                .d     (out_d),
                .q     (out_q)
        );

        assign hs = out_q.hs;
        assign vs = out_q.vs;
        assign r  = out_q.rgb[11:8];
        assign g  = out_q.rgb[7:4];
        assign b  = out_q.rgb[3:0];

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and power-on reset
// reset is released on a falling edge, after RESET_CYCLES rising edges

`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int PERIOD       = 20,
        parameter int RESET_CYCLES = 8
) (
        output logic pclk,
        output logic rst_n
);

        initial begin
                pclk = 1'b0;
                forever #(PERIOD / 2) pclk = ~pclk;
        end

        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge pclk);
                @(negedge pclk);
                rst_n = 1'b1;
        end

endmodule

// ==== vga_checker.sv ====
// monitor with its own frame model that compares every port on every rising edge
// XPOS and YPOS must match the DUT; the model restarts at (0, 0) on rst_n
// outputs sampled at the rising edge hold the values of the cycle just ended

`timescale 1ns/1ps

`include "vga_defines.svh"

module vga_checker #(
        parameter int XPOS = 128,
        parameter int YPOS = 99
) (
        input  logic       pclk,
        input  logic       rst_n,
        input  logic       hs,
        input  logic       vs,
        input  logic [3:0] r,
        input  logic [3:0] g,
        input  logic [3:0] b,
        output int         error_count,
        output int         check_count,
        output int         rect_count
);

        localparam int LAST = `PIPE_DEPTH - 1;

        int mh;
        int mv;
        int h_dly [`PIPE_DEPTH];
        int v_dly [`PIPE_DEPTH];
        bit val_dly [`PIPE_DEPTH];
        int errors = 0;
        int checks = 0;
        int rect_pixels = 0;

        assign error_count = errors;
        assign check_count = checks;
        assign rect_count  = rect_pixels;

        function automatic string pixel_region(input int h, input int v);
                if (h >= `H_ACTIVE || v >= `V_ACTIVE) return "blanking";
                if (h >= XPOS && h < XPOS + `RECT_W && v >= YPOS && v < YPOS + `RECT_H)
                        return "rectangle";
                if (h == 0 || h == `H_ACTIVE - 1 || v == 0 || v == `V_ACTIVE - 1)
                        return "frame";
                return "background";
        endfunction

        function automatic int region_colour(input string region);
                if (region == "rectangle") return 'hf80;
                if (region == "frame") return 'hfff;
                if (region == "background") return 'h48c;
                return 'h000;
        endfunction

        task automatic compare_value(input string name, input int h, input int v,
                                     input int expected, input int actual);
                checks++;
                if (expected != actual) begin
                        errors++;
                        $display("[FAIL] %s at (%0d, %0d): expected %0h, actual %0h",
                                 name, h, v, expected, actual);
                end
        endtask

        // model counters plus the three-cycle delay to the ports
        always @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        mh <= 0;
                        mv <= 0;
                        for (int i = 0; i < `PIPE_DEPTH; i++) begin
                                h_dly[i]   <= 0;
                                v_dly[i]   <= 0;
                                val_dly[i] <= 1'b0;
                        end
                end else begin
                        h_dly[0]   <= mh;
                        v_dly[0]   <= mv;
                        val_dly[0] <= 1'b1;
                        for (int i = 1; i < `PIPE_DEPTH; i++) begin
                                h_dly[i]   <= h_dly[i-1];
                                v_dly[i]   <= v_dly[i-1];
                                val_dly[i] <= val_dly[i-1];
                        end
                        if (mh == `H_TOTAL - 1) begin
                                mh <= 0;
                                mv <= (mv == `V_TOTAL - 1) ? 0 : mv + 1;
                        end else begin
                                mh <= mh + 1;
                        end
                end
        end

        always @(posedge pclk) begin
                string region;
                int    h;
                int    v;
                int    hs_exp;
                int    vs_exp;
                h = h_dly[LAST];
                v = v_dly[LAST];
                if (!val_dly[LAST]) begin
                        // in reset or still filling the pipeline
                        compare_value("reset hs", h, v, 0, int'(hs));
                        compare_value("reset vs", h, v, 0, int'(vs));
                        compare_value("reset colour", h, v, 0, int'({r, g, b}));
                end else begin
                        hs_exp = (h >= `H_ACTIVE + `H_FRONT &&
                                  h < `H_ACTIVE + `H_FRONT + `H_SYNC) ? 1 : 0;
                        vs_exp = (v >= `V_ACTIVE + `V_FRONT &&
                                  v < `V_ACTIVE + `V_FRONT + `V_SYNC) ? 1 : 0;
                        region = pixel_region(h, v);
                        // rectangle pixels that the DUT really drew
                        if (region == "rectangle" &&
                            int'({r, g, b}) == region_colour(region)) begin
                                rect_pixels++;
                        end
                        compare_value("hsync", h, v, hs_exp, int'(hs));
                        compare_value("vsync", h, v, vs_exp, int'(vs));
                        compare_value(region, h, v, region_colour(region), int'({r, g, b}));
                end
        end

endmodule

// ==== tb_vga.sv ====
// testbench top for the XGA pipeline, default rectangle position
// reset is the only random input, with two pulses in the second and third frame
// a full run covers a little over three frames of 1344 x 806 cycles

`timescale 1ns/1ps

`include "vga_defines.svh"

module tb_vga;

        localparam int     CLK_PERIOD   = 20;
        localparam int     FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
        localparam int     PULSE_CYCLES = 8;
        localparam int     DRAW_BITS    = 20;
        localparam longint WATCHDOG_NS  = longint'(4 * FRAME_CYCLES + 5000) * CLK_PERIOD;

        logic        pclk;
        logic        gen_rst_n;
        logic        pulse_n;
        logic        rst_n;
        logic        hs;
        logic        vs;
        logic [3:0]  r;
        logic [3:0]  g;
        logic [3:0]  b;
        int          error_count;
        int          check_count;
        int          rect_count;
        int          tb_errors;
        int          first_at;
        int          second_at;
        logic [15:0] lfsr_state;

        assign rst_n = gen_rst_n & pulse_n;

        tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) i_clock_gen (
                .pclk  (pclk),
                .rst_n (gen_rst_n)
        );

        vga_pipeline_top i_dut (
                .pclk  (pclk),
                .rst_n (rst_n),
                .hs    (hs),
                .vs    (vs),
                .r     (r),
                .g     (g),
                .b     (b)
        );

        vga_checker #(.XPOS(128), .YPOS(99)) i_checker (
                .pclk        (pclk),
                .rst_n       (rst_n),
                .hs          (hs),
                .vs          (vs),
                .r           (r),
                .g           (g),
                .b           (b),
                .error_count (error_count),
                .check_count (check_count),
                .rect_count  (rect_count)
        );

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                logic fb;
                fb = s[15] ^ s[13] ^ s[12] ^ s[10];
                return {s[14:0], fb};
        endfunction

        task automatic draw_random(input int nbits, output int value);
                value = 0;
                for (int i = 0; i < nbits; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        value = (value << 1) | int'(lfsr_state[0]);
                end
        endtask

        task automatic pulse_reset(input int wait_cycles);
                repeat (wait_cycles) @(negedge pclk);
                pulse_n = 1'b0;
                repeat (PULSE_CYCLES) @(negedge pclk);
                pulse_n = 1'b1;
        endtask

        initial begin
                lfsr_state = 16'd5;
                pulse_n    = 1'b1;
                tb_errors  = 0;
                draw_random(DRAW_BITS, first_at);
                draw_random(DRAW_BITS, second_at);
                // 2^20 is below one frame, so each moment stays in its frame
                first_at  = FRAME_CYCLES + first_at;
                second_at = 2 * FRAME_CYCLES + second_at;
                @(posedge gen_rst_n);
                $display("reset pulses at cycles %0d and %0d", first_at, second_at);
                pulse_reset(first_at);
                pulse_reset(second_at - first_at - PULSE_CYCLES);
                // one whole frame after the last restart and the pipeline delay
                repeat (FRAME_CYCLES + 16) @(negedge pclk);
                if (rect_count < 2 * `RECT_W * `RECT_H) begin
                        tb_errors++;
                        $display("the rectangle was drawn on only %0d pixels, %s",
                                 rect_count, "fewer than two whole frames hold");
                end
                $display("%0d checks, %0d mismatches, %0d other errors",
                         check_count, error_count, tb_errors);
                if (error_count == 0 && tb_errors == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_NS);
                $display("timeout: the run did not end within four frames and a margin");
                $display("CHECKS FAILED");
                $finish;
        end

endmodule

// ==== flist.f ====
+incdir+.
vga_timing_pkg.sv
vga_color_pkg.sv
pixel_delay.sv
vga_timing.sv
draw_background.sv
draw_rect.sv
vga_pipeline_top.sv
tb_clock_gen.sv
vga_checker.sv
tb_vga.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and search the log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_vga -f flist.f \
        --Mdir obj_dir -o tb_vga_sim 2>&1 | tee build.log &&
        ./obj_dir/tb_vga_sim 2>&1 | tee sim.log ||
        { echo "build or simulation did not complete"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } ||
        echo "simulation passed"
